// File: source/a2_timing_pkg.sv
// ==========================================================================
// Apple II bus timing package
// Shared phase, clock-state and lock-command types plus lock constants
// ==========================================================================

package a2_timing_pkg;

    // Phase index within one CPU cycle, 0 to 13
    typedef logic [3:0] phase_t;

    // Number of 14M ticks in a normal CPU cycle
    localparam int PHASE_COUNT = 14;

    // Apple clock levels with 7M as the MSB so a phase map entry reads as 7M, Phi1, Q3
    typedef struct packed {
        logic clk_7m;
        logic phi1;
        logic q3;
    } a2_clocks_t;

    // One-cycle commands from the lock controller to the phase engine
    typedef struct packed {
        // Load phase 0 and preload the accumulator
        logic snap;
        // Add a quarter step on top of the nominal step for one clock
        logic trim_fast;
        // Take a quarter step away from the nominal step for one clock
        logic trim_slow;
    } lock_cmd_t;

    // Lock FSM states
    typedef enum logic [1:0] {
        UNLOCKED  = 2'd0,
        ACQUIRING = 2'd1,
        LOCKED    = 2'd2
    } lock_state_e;

    // Clocks from an input change to the detected edge pulse
    localparam int SYNC_LATENCY = 3;

    // Tolerance in logic clocks around the expected edge offset
    localparam int ACCEPT_WINDOW = 2;

    // Consecutive in-window rises needed to declare lock
    localparam int LOCK_THRESHOLD = 8;

    // Consecutive misses that drop the controller back to UNLOCKED
    localparam int UNLOCK_THRESHOLD = 4;

endpackage

// File: source/a2_edge_sync.sv
// ==========================================================================
// Input edge synchronizer
// Brings an asynchronous level into the logic clock and pulses on its rise
// ==========================================================================

module a2_edge_sync (
    input  logic clk_logic_i,
    input  logic rst_i,
    input  logic async_i,
    output logic rise_o
);

    // Two-flop synchronizer, then a history flop of the clean level
    logic meta_q;
    logic sync_q;
    logic hist_q;

    always_ff @(posedge clk_logic_i) begin
        if (rst_i) begin
            meta_q <= 1'b0;
            sync_q <= 1'b0;
            hist_q <= 1'b0;
            rise_o <= 1'b0;
        end else begin
            meta_q <= async_i;
            sync_q <= meta_q;
            hist_q <= sync_q;
            // Registered pulse lands three edges after the first high sample
            rise_o <= sync_q & ~hist_q;
        end
    end

endmodule

// File: source/a2_phase_engine.sv
// ==========================================================================
// Predictive phase engine
// Fractional-N 14M tick generator driving a 14-step Apple II phase map
// ==========================================================================

module a2_phase_engine #(
    parameter int CLOCK_SPEED_HZ = 54_000_000,
    parameter int APPLE_HZ       = 14_318_181
) (
    input  logic                      clk_logic_i,
    input  logic                      rst_i,
    input  a2_timing_pkg::lock_cmd_t  cmd_i,
    output a2_timing_pkg::a2_clocks_t clocks_o,
    output logic                      phi1_rise_o,
    output logic                      phi1_fall_o,
    output logic                      q3_rise_o,
    output logic                      q3_fall_o,
    output logic                      m7_rise_o,
    output logic                      m7_fall_o
);

    import a2_timing_pkg::*;

    // ======================================================================
    // Accumulator constants
    // ======================================================================

    // Two spare bits cover the trimmed step and the snap preload
    localparam int ACC_W = $clog2(CLOCK_SPEED_HZ) + 2;
    typedef logic [ACC_W-1:0] acc_t;

    localparam acc_t LIMIT     = acc_t'(CLOCK_SPEED_HZ);
    localparam acc_t STEP      = acc_t'(APPLE_HZ);
    localparam acc_t STEP_FAST = acc_t'(APPLE_HZ + APPLE_HZ / 4);
    localparam acc_t STEP_SLOW = acc_t'(APPLE_HZ - APPLE_HZ / 4);
    // The real edge is SYNC_LATENCY clocks old by the time a snap arrives
    localparam acc_t PRELOAD   = acc_t'(SYNC_LATENCY * APPLE_HZ);

    localparam phase_t LAST_PHASE = phase_t'(PHASE_COUNT - 1);

    // 7M is the phase LSB, Phi1 is high in phases 0 to 6 and Q3 in 0 to 3 and 7 to 10
    localparam a2_clocks_t PHASE_MAP [PHASE_COUNT] = '{
        3'b011, 3'b111, 3'b011, 3'b111, 3'b010, 3'b110, 3'b010,
        3'b101, 3'b001, 3'b101, 3'b001, 3'b100, 3'b000, 3'b100
    };

    acc_t       acc_q;
    acc_t       acc_sum;
    acc_t       acc_d;
    phase_t     phase_q;
    phase_t     phase_d;
    logic       tick;
    a2_clocks_t clocks_q;
    a2_clocks_t clocks_hist_q;

    // ======================================================================
    // Next-state logic
    // ======================================================================

    always_comb begin
        // Trims bend the step for a single clock only
        if (cmd_i.trim_fast) begin
            acc_sum = acc_q + STEP_FAST;
        end else if (cmd_i.trim_slow) begin
            acc_sum = acc_q + STEP_SLOW;
        end else begin
            acc_sum = acc_q + STEP;
        end

        if (cmd_i.snap) begin
            // Restart at phase 0 and catch up if the preload already overflows
            tick    = (PRELOAD >= LIMIT);
            acc_d   = tick ? PRELOAD - LIMIT : PRELOAD;
            phase_d = '0;
        end else begin
            tick    = (acc_sum >= LIMIT);
            acc_d   = tick ? acc_sum - LIMIT : acc_sum;
            phase_d = phase_q;
        end

        if (tick) begin
            phase_d = (phase_d == LAST_PHASE) ? '0 : phase_d + 4'd1;
        end
    end

    // ======================================================================
    // State and output registers
    // ======================================================================

    always_ff @(posedge clk_logic_i) begin
        if (rst_i) begin
            acc_q         <= '0;
            phase_q       <= '0;
            clocks_q      <= PHASE_MAP[0];
            clocks_hist_q <= PHASE_MAP[0];
        end else begin
            acc_q         <= acc_d;
            phase_q       <= phase_d;
            // Decode the next phase so levels change on the tick's own edge
            clocks_q      <= PHASE_MAP[phase_d];
            clocks_hist_q <= clocks_q;
        end
    end

    assign clocks_o = clocks_q;

    // Edge pulses come from the level register against its history
    assign phi1_rise_o = clocks_q.phi1 & ~clocks_hist_q.phi1;
    assign phi1_fall_o = ~clocks_q.phi1 & clocks_hist_q.phi1;
    assign q3_rise_o   = clocks_q.q3 & ~clocks_hist_q.q3;
    assign q3_fall_o   = ~clocks_q.q3 & clocks_hist_q.q3;
    assign m7_rise_o   = clocks_q.clk_7m & ~clocks_hist_q.clk_7m;
    assign m7_fall_o   = ~clocks_q.clk_7m & clocks_hist_q.clk_7m;

endmodule

// File: source/a2_lock_ctrl.sv
// ==========================================================================
// Phase lock controller
// Compares input Phi1 rises with predicted ones, snaps or trims the engine
// ==========================================================================

module a2_lock_ctrl #(
    parameter int CLOCK_SPEED_HZ = 54_000_000,
    parameter int APPLE_HZ       = 14_318_181
) (
    input  logic                     clk_logic_i,
    input  logic                     rst_i,
    input  logic                     phi1_rise_i,
    input  logic                     pred_phi1_rise_i,
    output a2_timing_pkg::lock_cmd_t cmd_o,
    output logic                     lock_o,
    output logic                     error_o
);

    import a2_timing_pkg::*;

    // Logic clocks per CPU cycle, rounded up
    localparam int CYCLE_CLKS =
        int'((longint'(CLOCK_SPEED_HZ) * PHASE_COUNT + APPLE_HZ - 1) / APPLE_HZ);
    localparam int OFF_W = $clog2(CYCLE_CLKS) + 1;
    typedef logic [OFF_W-1:0] offset_t;

    localparam offset_t OFF_MAX       = '1;
    localparam offset_t CENTER        = offset_t'(SYNC_LATENCY);
    localparam offset_t NEAR_CUR_MAX  = offset_t'(SYNC_LATENCY + ACCEPT_WINDOW);
    localparam offset_t NEAR_NEXT_MIN = offset_t'(CYCLE_CLKS - ACCEPT_WINDOW);
    // Shorter than a cycle so the next rise is never blocked by jitter
    localparam offset_t HOLDOFF       = offset_t'(CYCLE_CLKS - 2 * ACCEPT_WINDOW - 1);

    offset_t     offset_q;
    offset_t     cooldown_q;
    lock_state_e state_q;
    logic [3:0]  good_q;
    logic [3:0]  miss_q;
    lock_cmd_t   cmd_q;
    logic        error_q;
    logic        near_cur;
    logic        near_next;
    logic        in_window;
    logic        missed;

    // Saturating count of clocks since the predicted Phi1 rise
    always_ff @(posedge clk_logic_i) begin
        if (rst_i) begin
            offset_q <= OFF_MAX;
        end else if (pred_phi1_rise_i) begin
            offset_q <= '0;
        end else if (offset_q != OFF_MAX) begin
            offset_q <= offset_q + 1'b1;
        end
    end

    // A rise just after the predicted edge, or just before the next one, is good
    assign near_cur  = (offset_q <= NEAR_CUR_MAX);
    assign near_next = (offset_q >= NEAR_NEXT_MIN);
    assign in_window = phi1_rise_i & (near_cur | near_next);
    assign missed    = phi1_rise_i & ~(near_cur | near_next);

    // ======================================================================
    // Lock FSM
    // ======================================================================

    always_ff @(posedge clk_logic_i) begin
        if (rst_i) begin
            state_q    <= UNLOCKED;
            good_q     <= '0;
            miss_q     <= '0;
            cooldown_q <= '0;
            cmd_q      <= '0;
            error_q    <= 1'b0;
        end else begin
            // Commands live for one clock only
            cmd_q <= '0;
            if (cooldown_q != '0) begin
                cooldown_q <= cooldown_q - 1'b1;
            end

            case (state_q)
                UNLOCKED: begin
                    good_q     <= '0;
                    miss_q     <= '0;
                    cooldown_q <= '0;
                    // Any rise is taken as phase 0
                    if (phi1_rise_i) begin
                        cmd_q.snap <= 1'b1;
                        state_q    <= ACQUIRING;
                    end
                end
                ACQUIRING: begin
                    if (in_window) begin
                        good_q <= good_q + 1'b1;
                        miss_q <= '0;
                        if (good_q >= LOCK_THRESHOLD - 1) begin
                            state_q <= LOCKED;
                            error_q <= 1'b0;
                        end
                    end else if (missed) begin
                        good_q <= '0;
                        miss_q <= miss_q + 1'b1;
                        if (miss_q >= UNLOCK_THRESHOLD - 1) begin
                            state_q <= UNLOCKED;
                        end
                    end
                end
                LOCKED: begin
                    if (in_window) begin
                        miss_q <= '0;
                        // Early or near the next edge means the engine runs slow
                        if (cooldown_q == '0) begin
                            if ((near_next && !near_cur) || offset_q < CENTER) begin
                                cmd_q.trim_fast <= 1'b1;
                                cooldown_q      <= HOLDOFF;
                            end else if (offset_q > CENTER) begin
                                cmd_q.trim_slow <= 1'b1;
                                cooldown_q      <= HOLDOFF;
                            end
                        end
                    end else if (missed) begin
                        good_q  <= '0;
                        miss_q  <= miss_q + 1'b1;
                        error_q <= 1'b1;
                        if (miss_q >= UNLOCK_THRESHOLD - 1) begin
                            state_q <= UNLOCKED;
                        end
                    end
                end
                default: begin
                    state_q <= UNLOCKED;
                end
            endcase
        end
    end

    assign cmd_o   = cmd_q;
    assign lock_o  = (state_q == LOCKED);
    assign error_o = error_q;

endmodule

// File: source/a2bus_timing.sv
// ==========================================================================
// Apple II bus timing top level
// Synchronizer, predictive phase engine and lock controller wired together
// ==========================================================================

module a2bus_timing #(
    parameter int CLOCK_SPEED_HZ = 54_000_000,
    parameter int APPLE_HZ       = 14_318_181
) (
    input  logic clk_logic_i,
    input  logic rst_i,
    input  logic a2_phi1_i,
    output logic lock_o,
    output logic error_o,
    output logic phi0_o,
    output logic phi0_posedge_o,
    output logic phi0_negedge_o,
    output logic phi1_o,
    output logic phi1_posedge_o,
    output logic phi1_negedge_o,
    output logic q3_o,
    output logic q3_posedge_o,
    output logic q3_negedge_o,
    output logic clk_7m_o,
    output logic clk_7m_posedge_o,
    output logic clk_7m_negedge_o,
    output logic clk_14m_posedge_o
);

    import a2_timing_pkg::*;

    logic       phi1_rise;
    lock_cmd_t  lock_cmd;
    a2_clocks_t clocks;

    // Input side only feeds the phase comparison
    a2_edge_sync u_edge_sync (
        .clk_logic_i (clk_logic_i),
        .rst_i       (rst_i),
        .async_i     (a2_phi1_i),
        .rise_o      (phi1_rise)
    );

    // Free-running engine is the only source of output timing
    a2_phase_engine #(
        .CLOCK_SPEED_HZ (CLOCK_SPEED_HZ),
        .APPLE_HZ       (APPLE_HZ)
    ) u_phase_engine (
        .clk_logic_i (clk_logic_i),
        .rst_i       (rst_i),
        .cmd_i       (lock_cmd),
        .clocks_o    (clocks),
        .phi1_rise_o (phi1_posedge_o),
        .phi1_fall_o (phi1_negedge_o),
        .q3_rise_o   (q3_posedge_o),
        .q3_fall_o   (q3_negedge_o),
        .m7_rise_o   (clk_7m_posedge_o),
        .m7_fall_o   (clk_7m_negedge_o)
    );

    // Predicted Phi1 rise is the engine's own registered pulse
    a2_lock_ctrl #(
        .CLOCK_SPEED_HZ (CLOCK_SPEED_HZ),
        .APPLE_HZ       (APPLE_HZ)
    ) u_lock_ctrl (
        .clk_logic_i      (clk_logic_i),
        .rst_i            (rst_i),
        .phi1_rise_i      (phi1_rise),
        .pred_phi1_rise_i (phi1_posedge_o),
        .cmd_o            (lock_cmd),
        .lock_o           (lock_o),
        .error_o          (error_o)
    );

    assign phi1_o   = clocks.phi1;
    assign q3_o     = clocks.q3;
    assign clk_7m_o = clocks.clk_7m;

    // Phi0 is Phi1 inverted, so its edges swap
    assign phi0_o         = ~clocks.phi1;
    assign phi0_posedge_o = phi1_negedge_o;
    assign phi0_negedge_o = phi1_posedge_o;

    // Every 7M transition is one 14M tick
    assign clk_14m_posedge_o = clk_7m_posedge_o | clk_7m_negedge_o;

endmodule

// File: tests/tb_clock_gen.sv
// ==========================================================================
// Testbench clock and reset source
// 40 ns logic clock with reset held high for the first three cycles
// ==========================================================================

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Reset drops on the third rising edge
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: tests/a2bus_timing_assertions.sv
// ==========================================================================
// Apple II bus timing checker
// Concurrent checks on reset state, edge pulses, decode and the phase map
// ==========================================================================

module a2bus_timing_assertions (
    input logic clk_logic_i,
    input logic rst_i,
    input logic lock_i,
    input logic error_i,
    input logic phi0_i,
    input logic phi0_rise_i,
    input logic phi0_fall_i,
    input logic phi1_i,
    input logic phi1_rise_i,
    input logic phi1_fall_i,
    input logic q3_i,
    input logic q3_rise_i,
    input logic q3_fall_i,
    input logic m7_i,
    input logic m7_rise_i,
    input logic m7_fall_i,
    input logic m14_tick_i
);

    timeunit 1ns;
    timeprecision 1ps;

    import a2_timing_pkg::*;

    // Failed checks, read by the testbench for its per-test lines
    int fail_count = 0;

    a2_clocks_t clocks;
    logic       span_q;
    logic [7:0] tick_cnt_q;
    logic [7:0] q3_cnt_q;
    logic [7:0] fall_cnt_q;

    assign clocks = '{clk_7m: m7_i, phi1: phi1_i, q3: q3_i};

    // ======================================================================
    // Per-cycle bookkeeping between two Phi1 rises
    // ======================================================================

    // A span only counts when lock was held from its opening rise onwards
    always_ff @(posedge clk_logic_i) begin
        if (rst_i) begin
            span_q     <= 1'b0;
            tick_cnt_q <= '0;
            q3_cnt_q   <= '0;
            fall_cnt_q <= '0;
        end else if (phi1_rise_i) begin
            span_q     <= lock_i;
            tick_cnt_q <= '0;
            q3_cnt_q   <= '0;
            fall_cnt_q <= '0;
        end else begin
            if (!lock_i) begin
                span_q <= 1'b0;
            end
            tick_cnt_q <= tick_cnt_q + 8'(m14_tick_i);
            q3_cnt_q   <= q3_cnt_q + 8'(q3_rise_i);
            fall_cnt_q <= fall_cnt_q + 8'(phi1_fall_i);
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================

    a_reset_quiet: assert property (@(posedge clk_logic_i) rst_i |=>
        (!lock_i && !error_i && !phi1_rise_i && !phi1_fall_i && !q3_rise_i &&
         !q3_fall_i && !m7_rise_i && !m7_fall_i && !m14_tick_i))
        else begin $error("outputs not quiet after reset"); fail_count++; end

    a_phi1_rise: assert property (@(posedge clk_logic_i) disable iff (rst_i)
        phi1_rise_i == (clocks.phi1 && !$past(clocks.phi1)))
        else begin $error("phi1 rising pulse mismatch"); fail_count++; end

    a_phi1_fall: assert property (@(posedge clk_logic_i) disable iff (rst_i)
        phi1_fall_i == (!clocks.phi1 && $past(clocks.phi1)))
        else begin $error("phi1 falling pulse mismatch"); fail_count++; end

    a_q3_rise: assert property (@(posedge clk_logic_i) disable iff (rst_i)
        q3_rise_i == (clocks.q3 && !$past(clocks.q3)))
        else begin $error("q3 rising pulse mismatch"); fail_count++; end

    a_q3_fall: assert property (@(posedge clk_logic_i) disable iff (rst_i)
        q3_fall_i == (!clocks.q3 && $past(clocks.q3)))
        else begin $error("q3 falling pulse mismatch"); fail_count++; end

    a_m7_rise: assert property (@(posedge clk_logic_i) disable iff (rst_i)
        m7_rise_i == (clocks.clk_7m && !$past(clocks.clk_7m)))
        else begin $error("7M rising pulse mismatch"); fail_count++; end

    a_m7_fall: assert property (@(posedge clk_logic_i) disable iff (rst_i)
        m7_fall_i == (!clocks.clk_7m && $past(clocks.clk_7m)))
        else begin $error("7M falling pulse mismatch"); fail_count++; end

    a_phi0_inverse: assert property (@(posedge clk_logic_i)
        (phi0_i == !phi1_i) && (phi0_rise_i == phi1_fall_i) && (phi0_fall_i == phi1_rise_i))
        else begin $error("phi0 is not the inverse of phi1"); fail_count++; end

    // 7M toggles on every 14M tick and on no other cycle
    a_m14_tick: assert property (@(posedge clk_logic_i) disable iff (rst_i)
        m14_tick_i == (clocks.clk_7m != $past(clocks.clk_7m)))
        else begin $error("14M tick does not match a 7M toggle"); fail_count++; end

    // The closing rise is itself the fourteenth tick of the span
    a_ticks_per_cycle: assert property (@(posedge clk_logic_i) disable iff (rst_i)
        (phi1_rise_i && lock_i && span_q) |->
        (tick_cnt_q == 8'd13 && q3_cnt_q + 8'(q3_rise_i) == 8'd2 && fall_cnt_q == 8'd1))
        else begin $error("locked CPU cycle breaks the phase map"); fail_count++; end

    a_phi1_fall_phase: assert property (@(posedge clk_logic_i) disable iff (rst_i)
        (phi1_fall_i && lock_i && span_q) |-> (tick_cnt_q == 8'd6))
        else begin $error("phi1 fell away from the seventh tick"); fail_count++; end

    // Error only clears on the way into lock
    a_error_sticky: assert property (@(posedge clk_logic_i) disable iff (rst_i)
        $fell(error_i) |-> $rose(lock_i))
        else begin $error("error flag cleared without a new lock"); fail_count++; end

endmodule

bind a2bus_timing a2bus_timing_assertions u_checks (
    .clk_logic_i (clk_logic_i),
    .rst_i       (rst_i),
    .lock_i      (lock_o),
    .error_i     (error_o),
    .phi0_i      (phi0_o),
    .phi0_rise_i (phi0_posedge_o),
    .phi0_fall_i (phi0_negedge_o),
    .phi1_i      (phi1_o),
    .phi1_rise_i (phi1_posedge_o),
    .phi1_fall_i (phi1_negedge_o),
    .q3_i        (q3_o),
    .q3_rise_i   (q3_posedge_o),
    .q3_fall_i   (q3_negedge_o),
    .m7_i        (clk_7m_o),
    .m7_rise_i   (clk_7m_posedge_o),
    .m7_fall_i   (clk_7m_negedge_o),
    .m14_tick_i  (clk_14m_posedge_o)
);

// File: tests/a2bus_timing_tb.sv
// ==========================================================================
// Apple II bus timing testbench
// Drives a 53-clock Phi1 wave, shifts it by half a period and back again
// ==========================================================================

module a2bus_timing_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import a2_timing_pkg::*;

    // Input wave in logic clocks, and the jump used for the half-period shift
    localparam int IN_PERIOD  = 53;
    localparam int IN_HIGH    = 28;
    localparam int HALF_SHIFT = 26;
    localparam int SHIFT_POS  = 40;

    logic clk_logic;
    logic rst;
    logic a2_phi1 = 1'b0;
    logic lock_o;
    logic error_o;
    logic phi0_o;
    logic phi0_posedge_o;
    logic phi0_negedge_o;
    logic phi1_o;
    logic phi1_posedge_o;
    logic phi1_negedge_o;
    logic q3_o;
    logic q3_posedge_o;
    logic q3_negedge_o;
    logic clk_7m_o;
    logic clk_7m_posedge_o;
    logic clk_7m_negedge_o;
    logic clk_14m_posedge_o;

    int in_pos = 0;
    int rise_cnt = 0;
    int shift_req = 0;
    int shift_done = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic test_ok;

    tb_clock_gen u_clock_gen (
        .clk_o (clk_logic),
        .rst_o (rst)
    );

    a2bus_timing u_a2bus_timing (
        .clk_logic_i       (clk_logic),
        .rst_i             (rst),
        .a2_phi1_i         (a2_phi1),
        .lock_o            (lock_o),
        .error_o           (error_o),
        .phi0_o            (phi0_o),
        .phi0_posedge_o    (phi0_posedge_o),
        .phi0_negedge_o    (phi0_negedge_o),
        .phi1_o            (phi1_o),
        .phi1_posedge_o    (phi1_posedge_o),
        .phi1_negedge_o    (phi1_negedge_o),
        .q3_o              (q3_o),
        .q3_posedge_o      (q3_posedge_o),
        .q3_negedge_o      (q3_negedge_o),
        .clk_7m_o          (clk_7m_o),
        .clk_7m_posedge_o  (clk_7m_posedge_o),
        .clk_7m_negedge_o  (clk_7m_negedge_o),
        .clk_14m_posedge_o (clk_14m_posedge_o)
    );

    // ======================================================================
    // Apple Phi1 source whose phase jumps by half a period on a shift request
    // ======================================================================

    always @(posedge clk_logic) begin : input_wave
        int next_pos;
        if (rst) begin
            in_pos  <= 0;
            a2_phi1 <= 1'b0;
        end else begin
            next_pos = (in_pos + 1) % IN_PERIOD;
            if (shift_done != shift_req && in_pos == SHIFT_POS) begin
                next_pos = (in_pos + HALF_SHIFT) % IN_PERIOD;
                shift_done <= shift_done + 1;
            end
            in_pos  <= next_pos;
            a2_phi1 <= (next_pos < IN_HIGH);
            if (next_pos < IN_HIGH && !a2_phi1) begin
                rise_cnt <= rise_cnt + 1;
            end
        end
    end

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            test_ok = 1'b0;
        end
    endtask

    task automatic report_test(input int num, input string name);
        tests_run++;
        if (!test_ok) begin
            tests_failed++;
        end
        $display("[%0d ns] test %0d %s: %s", $time, num, name, test_ok ? "ok" : "FAILED");
    endtask

    // Waits until lock_o shows the level, giving up after limit clocks
    task automatic wait_lock(input logic level, input int limit, input string what);
        int n;
        for (n = 0; n < limit; n++) begin
            @(negedge clk_logic);
            if (lock_o == level) begin
                return;
            end
        end
        $display("Timeout at %0d ns: %s", $time, what);
        test_ok = 1'b0;
    endtask

    // Runs until rise_cnt reaches target, holding lock and error at fixed levels
    task automatic run_to_rise(input int target, input logic lock_exp, input logic err_exp);
        int n;
        for (n = 0; n < 12 * IN_PERIOD; n++) begin
            @(negedge clk_logic);
            if (rise_cnt >= target) begin
                return;
            end
            check_bit("lock_o", lock_o, lock_exp);
            check_bit("error_o", error_o, err_exp);
        end
        $display("Timeout at %0d ns: input rise %0d never came", $time, target);
        test_ok = 1'b0;
    endtask

    initial begin : run_tests
        int unsigned seed;
        int burst;
        int base;
        int asserts_before;
        int n;
        seed  = lcg_next(32'd5639);
        burst = 4 + int'((seed >> 16) % 4);

        // Test 1 expects quiet outputs until the first 14M tick
        test_ok = 1'b1;
        for (n = 0; n < 10 && rst; n++) begin
            @(negedge clk_logic);
        end
        for (n = 0; n < 12; n++) begin
            @(negedge clk_logic);
            check_bit("lock_o", lock_o, 1'b0);
            check_bit("error_o", error_o, 1'b0);
            if (clk_14m_posedge_o) begin
                break;
            end
            check_bit("edge pulses", |{phi1_posedge_o, phi1_negedge_o, q3_posedge_o,
                      q3_negedge_o, clk_7m_posedge_o, clk_7m_negedge_o}, 1'b0);
        end
        if (n == 12) begin
            $display("Timeout at %0d ns: no 14M tick after reset", $time);
            test_ok = 1'b0;
        end
        report_test(1, "reset state");

        // Test 4 runs early because the later tests need lock
        test_ok = 1'b1;
        wait_lock(1'b1, 12 * IN_PERIOD, "lock_o did not rise in 12 input cycles");
        if (rise_cnt > LOCK_THRESHOLD + 2) begin
            $display("** Error at %0d ns: rise_cnt = %0d, expected at most %0d",
                     $time, rise_cnt, LOCK_THRESHOLD + 2);
            test_ok = 1'b0;
        end
        run_to_rise(rise_cnt + 6, 1'b1, 1'b0);
        report_test(4, "lock acquisition");

        // Tests 2 and 3 are judged by the bound checker while locked
        for (n = 2; n <= 3; n++) begin
            test_ok        = 1'b1;
            asserts_before = u_a2bus_timing.u_checks.fail_count;
            run_to_rise(rise_cnt + 3, 1'b1, 1'b0);
            if (u_a2bus_timing.u_checks.fail_count != asserts_before) begin
                $display("Checker assertions failed during test %0d", n);
                test_ok = 1'b0;
            end
            report_test(n, n == 2 ? "edge pulses and decode" : "phase map");
        end

        // Test 5 shifts the input by half a period for a burst of edges
        test_ok = 1'b1;
        base    = rise_cnt;
        shift_req++;
        run_to_rise(base + 1, 1'b1, 1'b0);
        for (n = 0; n < 10 && !error_o; n++) begin
            @(negedge clk_logic);
        end
        check_bit("error_o", error_o, 1'b1);
        run_to_rise(base + UNLOCK_THRESHOLD, 1'b1, 1'b1);
        wait_lock(1'b0, 10, "lock_o did not fall after the shifted edges");
        run_to_rise(base + burst, 1'b0, 1'b1);
        report_test(5, $sformatf("error and lock loss, %0d edges", burst));

        // Test 6 returns the input to nominal and waits for lock again
        test_ok = 1'b1;
        shift_req++;
        wait_lock(1'b1, 30 * IN_PERIOD, "lock_o did not return after recovery");
        run_to_rise(rise_cnt + 4, 1'b1, 1'b0);
        report_test(6, "recovery");

        $display("Tests run %0d, failed %0d, checker failures %0d",
                 tests_run, tests_failed, u_a2bus_timing.u_checks.fail_count);
        if (tests_failed == 0 && u_a2bus_timing.u_checks.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: flist.f
source/a2_timing_pkg.sv
source/a2_edge_sync.sv
source/a2_phase_engine.sv
source/a2_lock_ctrl.sv
source/a2bus_timing.sv
tests/tb_clock_gen.sv
tests/a2bus_timing_assertions.sv
tests/a2bus_timing_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the Apple II bus timing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module a2bus_timing_tb \
    -Mdir build \
    -f flist.f > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Compile failed, see build.log"
    exit 1
fi

./build/Va2bus_timing_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation returned an error, see sim.log"
    exit 1
fi

if grep -q "Testbench passed" sim.log; then
    echo "PASS"
    exit 0
fi

echo "FAIL, see sim.log"
exit 1
